// File: files.f
+incdir+logic
logic/datapath_pkg.sv
logic/microSequencer.sv
logic/controlRom.sv
logic/aluCore.sv
logic/regPortSelect.sv
logic/registerCell.sv
logic/operandSelect.sv
logic/datapathTop.sv
tests/datapath_properties.sv
tests/datapath_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if ! verilator --binary --assert -f files.f --top-module datapathTb -o datapathSim \
    > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/datapathSim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi

exit 0

// File: tests/datapath_tb.sv
// Datapath testbench
`include "datapath_config.svh"

module datapathTb;
  import datapathPkg::*;

  localparam int dataCount = 16;
  localparam int instrCount = 1 + dataCount + 8 + 3 + 2 + 6;
  localparam int cycleLimit = instrCount * 6 + 100;

  logic   clk;
  logic   rstN;
  wordT   instr;
  logic   instrValid;
  logic   ready;
  logic   rfWrite;
  regIdxT rfWriteAddr;
  wordT   rfWriteData;
  flagsT  flags;

  // Register and flag model, expected writes as {addr, data}
  wordT        regs [`REG_COUNT];
  flagsT       flagsModel;
  logic [35:0] expQ [$];
  int          errors;
  logic [31:0] lcgState;

  datapathTop datapathTop_inst (
    .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid), .ready(ready),
    .rfWrite(rfWrite), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData), .flags(flags)
  );

  bind datapathTop datapathProperties datapathProperties_inst (
    .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid), .ready(ready),
    .rfWrite(rfWrite), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData), .flags(flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    repeat (cycleLimit) @(posedge clk);
    $display("Watchdog expired after %0d cycles", cycleLimit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic wordT dataImm(input logic [3:0] op, input logic s, input logic [3:0] rn,
                                   input logic [3:0] rd, input logic [7:0] imm);
    return {4'hE, 3'b001, op, s, rn, rd, 4'h0, imm};
  endfunction

  // Returns {carry, overflow, result}
  function automatic logic [33:0] addWithCarry(input wordT x, input wordT y, input logic cin);
    logic [32:0] wide;
    logic        v;
    wide = {1'b0, x} + {1'b0, y} + 33'(cin);
    v = (x[31] == y[31]) && (wide[31] != x[31]);
    return {wide[32], v, wide[31:0]};
  endfunction

  // Carry is the ARM not-borrow
  function automatic logic [33:0] subtractWithBorrow(input wordT x, input wordT y,
                                                      input logic borrow);
    wordT r;
    logic c;
    logic v;
    r = x - y - wordT'(borrow);
    c = {1'b0, x} >= ({1'b0, y} + 33'(borrow));
    v = (x[31] != y[31]) && (r[31] != x[31]);
    return {c, v, r};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
    begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic modelDataImm(input wordT word);
    logic [3:0] op;
    wordT       a;
    wordT       b;
    wordT       res;
    logic       c;
    logic       v;
    logic       isCompare;
    op = word[24:21];
    a = regs[word[19:16]];
    b = {24'd0, word[7:0]};
    c = flagsModel.c;
    v = 1'b0;
    isCompare = (op >= 4'd8) && (op <= 4'd11);
    case (op)
      4'd0, 4'd8:  res = a & b;
      4'd1, 4'd9:  res = a ^ b;
      4'd12:       res = a | b;
      4'd13:       res = b;
      4'd14:       res = a & ~b;
      4'd15:       res = ~b;
      4'd2, 4'd10: {c, v, res} = subtractWithBorrow(a, b, 1'b0);
      4'd3:        {c, v, res} = subtractWithBorrow(b, a, 1'b0);
      4'd4, 4'd11: {c, v, res} = addWithCarry(a, b, 1'b0);
      4'd5:        {c, v, res} = addWithCarry(a, b, flagsModel.c);
      4'd6:        {c, v, res} = subtractWithBorrow(a, b, !flagsModel.c);
      default:     {c, v, res} = subtractWithBorrow(b, a, !flagsModel.c);
    endcase
    if (word[20] || isCompare)
      flagsModel = {res[31], res == '0, c, v};
    if (!isCompare)
    begin
      regs[word[15:12]] = res;
      expQ.push_back({word[15:12], res});
    end
  endtask

  task automatic predictWrites(input wordT word, output int latency);
    wordT target;
    regs[`PC_INDEX] = regs[`PC_INDEX] + 32'(`PC_STEP);
    expQ.push_back({4'(`PC_INDEX), regs[`PC_INDEX]});
    latency = 3;
    if (word[27:25] == 3'b001)
      modelDataImm(word);
    else if (word[27:25] == 3'b101)
    begin
      if (word[24])
      begin
        regs[`LINK_INDEX] = regs[`PC_INDEX];
        expQ.push_back({4'(`LINK_INDEX), regs[`PC_INDEX]});
        latency = 4;
      end
      target = regs[`PC_INDEX] + {{6{word[23]}}, word[23:0], 2'b00} + 32'(`PC_STEP);
      regs[`PC_INDEX] = target;
      expQ.push_back({4'(`PC_INDEX), target});
    end
    else
      latency = 2;
  endtask

  task automatic observeWrite();
    logic [35:0] entry;
    if (rfWrite)
    begin
      if (expQ.size() == 0)
      begin
        errors++;
        $display("Unexpected register write to R%0d with data %h", rfWriteAddr, rfWriteData);
      end
      else
      begin
        entry = expQ.pop_front();
        checkValue("rfWriteAddr", 32'(rfWriteAddr), 32'(entry[35:32]));
        checkValue("rfWriteData", rfWriteData, entry[31:0]);
      end
    end
  endtask

  task automatic idleCycles(input int count);
    instrValid = 1'b0;
    repeat (count)
    begin
      instr = nextRandom();
      @(negedge clk);
      checkValue("ready", 32'(ready), 32'd1);
      observeWrite();
      @(posedge clk);
      #2;
    end
  endtask

  // Accepts one word and follows it until ready returns
  task automatic runInstruction(input wordT word);
    int latency;
    int cycles;
    predictWrites(word, latency);
    instr = word;
    instrValid = 1'b1;
    for (cycles = 0; cycles < 8; cycles++)
    begin
      @(negedge clk);
      observeWrite();
      if (cycles == 0)
        checkValue("ready", 32'(ready), 32'd1);
      else if (ready)
        break;
      @(posedge clk);
      #2;
      instrValid = 1'b0;
    end
    @(posedge clk);
    #2;
    checkValue("latency", cycles, latency);
    checkValue("flags", 32'(flags), 32'(flagsModel));
    if (expQ.size() != 0)
    begin
      errors++;
      $display("%0d expected register writes never happened for %h", expQ.size(), word);
      expQ.delete();
    end
  endtask

  task automatic checkResetState();
    @(negedge clk);
    checkValue("ready", 32'(ready), 32'd0);
    @(posedge clk);
    #2;
    checkValue("flags", 32'(flags), 32'd0);
    idleCycles(3);
    runInstruction(dataImm(4'd13, 1'b0, 4'd0, 4'd0, 8'h5a));
  endtask

  task automatic runDataSequence();
    logic [31:0] r;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rn;
    rn = 4'd0;
    for (int i = 0; i < dataCount; i++)
    begin
      r = nextRandom();
      case (i)
        0:       op = 4'd13;
        1:       op = 4'd4;
        2:       op = 4'd1;
        3:       op = 4'd14;
        // Compare opcodes are remapped to ORR..MVN
        default: op = (r[27:24] >= 4'd8 && r[27:24] <= 4'd11) ? r[27:24] + 4'd4 : r[27:24];
      endcase
      rd = 4'(i % 14);
      runInstruction(dataImm(op, r[31], rn, rd, r[23:16]));
      rn = rd;
    end
  endtask

  task automatic exerciseFlags();
    runInstruction(dataImm(4'd13, 1'b0, 4'd0, 4'd2, 8'd5));
    runInstruction(dataImm(4'd2, 1'b1, 4'd2, 4'd3, 8'd5));
    runInstruction(dataImm(4'd2, 1'b1, 4'd2, 4'd3, 8'd6));
    runInstruction(dataImm(4'd10, 1'b0, 4'd2, 4'd4, 8'd5));
    runInstruction(dataImm(4'd8, 1'b1, 4'd2, 4'd4, 8'd2));
    runInstruction(dataImm(4'd11, 1'b1, 4'd3, 4'd4, 8'd1));
    runInstruction(dataImm(4'd9, 1'b1, 4'd2, 4'd4, 8'd5));
    runInstruction(dataImm(4'd5, 1'b0, 4'd2, 4'd5, 8'd1));
  endtask

  task automatic takeBranches();
    logic [31:0] r;
    r = nextRandom();
    runInstruction({4'hE, 3'b101, 1'b0, 24'h000010});
    runInstruction({4'hE, 3'b101, 1'b0, 24'hfffff8});
    runInstruction({4'hE, 3'b101, 1'b0, {14{r[9]}}, r[9:0]});
  endtask

  task automatic branchWithLink();
    runInstruction({4'hE, 3'b101, 1'b1, 24'h000020});
    runInstruction({4'hE, 3'b101, 1'b1, 24'hffffd0});
  endtask

  task automatic skipUnknownClass();
    logic [31:0] r;
    for (int k = 0; k < 8; k++)
    begin
      r = nextRandom();
      if (k != 1 && k != 5)
        runInstruction({r[31:28], 3'(k), r[24:0]});
    end
    idleCycles(4);
  endtask

  initial
  begin
    errors = 0;
    lcgState = 32'h4fb348f5;
    rstN = 1'b0;
    instr = '0;
    instrValid = 1'b0;
    flagsModel = '0;
    for (int i = 0; i < `REG_COUNT; i++)
      regs[i] = '0;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    checkResetState();
    runDataSequence();
    exerciseFlags();
    takeBranches();
    branchWithLink();
    skipUnknownClass();
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: tests/datapath_properties.sv
// Datapath port assertions
`include "datapath_config.svh"

module datapathProperties (
  input logic                clk,
  input logic                rstN,
  input datapathPkg::wordT   instr,
  input logic                instrValid,
  input logic                ready,
  input logic                rfWrite,
  input datapathPkg::regIdxT rfWriteAddr,
  input datapathPkg::wordT   rfWriteData,
  input datapathPkg::flagsT  flags
);
  import datapathPkg::*;

  logic accepted;
  logic knownClass;

  assign accepted = ready && instrValid;
  assign knownClass = (instr[27:25] == 3'b001) || (instr[27:25] == 3'b101);

  readyDrops: assert property (@(posedge clk) disable iff (!rstN) accepted |=> !ready)
    else $error("ready still high the cycle after an accept");

  // Recognized classes stay out of fetch for a second cycle
  readyHeldLow: assert property (@(posedge clk) disable iff (!rstN)
    $past(accepted && knownClass, 2) |-> !ready)
    else $error("ready returned one cycle after accepting a known class");

  fetchWriteOnlyPc: assert property (@(posedge clk) disable iff (!rstN)
    (ready && rfWrite) |-> (instrValid && rfWriteAddr == regIdxT'(`PC_INDEX)))
    else $error("register write in fetch without a strobe or not to the PC");

  noUnknownOutputs: assert property (@(posedge clk) disable iff (!rstN)
    !$isunknown({ready, rfWrite, rfWriteAddr, rfWriteData, flags}))
    else $error("unknown value on a datapath output");

endmodule

// File: logic/datapathTop.sv
// Microprogrammed datapath top
`include "datapath_config.svh"

module datapathTop (
  input  logic                clk,
  input  logic                rstN,
  input  datapathPkg::wordT   instr,
  input  logic                instrValid,
  output logic                ready,
  output logic                rfWrite,
  output datapathPkg::regIdxT rfWriteAddr,
  output datapathPkg::wordT   rfWriteData,
  output datapathPkg::flagsT  flags
);
  import datapathPkg::*;

  ctrlWordT             ctrl;
  stateT                state;
  regIdxT               rn;
  regIdxT               rd;
  regIdxT               readIdx;
  logic [7:0]           imm8;
  logic [23:0]          offset24;
  aluOpT                opcode;
  logic                 sBit;
  logic                 isTest;
  logic                 rfEnQual;
  logic [`REG_COUNT-1:0] writeEn;
  wordT                 cellData [`REG_COUNT];
  wordT                 aOp;
  wordT                 bOp;

  // Fetch increments PC only when the host hands over a word
  assign rfEnQual = ctrl.rfEn & (instrValid | ~ready);

  microSequencer microSequencer_inst (
    .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid), .ctrl(ctrl),
    .state(state), .rn(rn), .rd(rd), .imm8(imm8), .offset24(offset24),
    .opcode(opcode), .sBit(sBit)
  );

  controlRom controlRom_inst (.state(state), .ctrl(ctrl), .ready(ready));

  aluCore aluCore_inst (
    .clk(clk), .rstN(rstN), .a(aOp), .b(bOp), .ctrlOp(ctrl.aluOp), .opcode(opcode),
    .aluSrc(ctrl.aluSrc), .flagsEn(ctrl.flagsEn), .sBit(sBit), .result(rfWriteData),
    .isTest(isTest), .flags(flags)
  );

  regPortSelect regPortSelect_inst (
    .rn(rn), .rd(rd), .aSel(ctrl.aSel), .cSel(ctrl.cSel), .rfEn(rfEnQual),
    .isTest(isTest), .readIdx(readIdx), .writeIdx(rfWriteAddr), .writeEn(writeEn),
    .rfWrite(rfWrite)
  );

  for (genvar i = 0; i < `REG_COUNT; i++)
  begin : cellGen
    registerCell #(.cellIndex(i)) registerCell_inst (
      .clk(clk), .rstN(rstN), .writeData(rfWriteData), .writeEn(writeEn[i]),
      .readIdx(readIdx), .readGated(cellData[i])
    );
  end

  operandSelect operandSelect_inst (
    .cellData(cellData), .bSel(ctrl.bSel), .imm8(imm8), .offset24(offset24),
    .a(aOp), .b(bOp)
  );

endmodule

// File: logic/operandSelect.sv
// ALU operand select
`include "datapath_config.svh"

module operandSelect (
  input  datapathPkg::wordT cellData [`REG_COUNT],
  input  datapathPkg::bSelT bSel,
  input  logic [7:0]        imm8,
  input  logic [23:0]       offset24,
  output datapathPkg::wordT a,
  output datapathPkg::wordT b
);
  import datapathPkg::*;

  wordT offsetExt;

  // At most one cell drives a nonzero value
  always_comb
  begin
    a = '0;
    for (int i = 0; i < `REG_COUNT; i++)
    begin
      a = a | cellData[i];
    end
  end

  assign offsetExt = {{(`DATA_WIDTH - 24){offset24[23]}}, offset24};

  assign b = (bSel == bSelOffset) ? (offsetExt << `OFFSET_SHIFT) : wordT'(imm8);

endmodule

// File: logic/registerCell.sv
// Register file cell
`include "datapath_config.svh"

module registerCell #(
  parameter int cellIndex = 0
) (
  input  logic                clk,
  input  logic                rstN,
  input  datapathPkg::wordT   writeData,
  input  logic                writeEn,
  input  datapathPkg::regIdxT readIdx,
  output datapathPkg::wordT   readGated
);
  import datapathPkg::*;

  wordT value;

  always_ff @(posedge clk)
  begin
    if (!rstN)
      value <= '0;
    else if (writeEn)
      value <= writeData;
  end

  // Drive zero unless selected so the outputs can be OR-combined
  assign readGated = (readIdx == regIdxT'(cellIndex)) ? value : '0;

endmodule

// File: logic/regPortSelect.sv
// Register port index select
`include "datapath_config.svh"

module regPortSelect (
  input  datapathPkg::regIdxT rn,
  input  datapathPkg::regIdxT rd,
  input  datapathPkg::aSelT   aSel,
  input  datapathPkg::cSelT   cSel,
  input  logic                rfEn,
  input  logic                isTest,
  output datapathPkg::regIdxT readIdx,
  output datapathPkg::regIdxT writeIdx,
  output logic [`REG_COUNT-1:0] writeEn,
  output logic                rfWrite
);
  import datapathPkg::*;

  assign readIdx = (aSel == aSelPc) ? regIdxT'(`PC_INDEX) : rn;

  always_comb
  begin
    case (cSel)
      cSelPc:  writeIdx = regIdxT'(`PC_INDEX);
      cSelLr:  writeIdx = regIdxT'(`LINK_INDEX);
      default: writeIdx = rd;
    endcase
  end

  // Compare opcodes only touch the flags
  assign rfWrite = rfEn & ~isTest;
  assign writeEn = rfWrite ? (`REG_COUNT'(1) << writeIdx) : '0;

endmodule

// File: logic/aluCore.sv
// ALU and status flags
`include "datapath_config.svh"

module aluCore (
  input  logic               clk,
  input  logic               rstN,
  input  datapathPkg::wordT  a,
  input  datapathPkg::wordT  b,
  input  datapathPkg::aluOpT ctrlOp,
  input  datapathPkg::aluOpT opcode,
  input  datapathPkg::aluSrcT aluSrc,
  input  logic               flagsEn,
  input  logic               sBit,
  output datapathPkg::wordT  result,
  output logic               isTest,
  output datapathPkg::flagsT flags
);
  import datapathPkg::*;

  aluOpT             op;
  wordT              addX;
  wordT              addY;
  logic              addCin;
  logic              isArith;
  logic [`DATA_WIDTH:0] sum;
  logic              overflow;
  flagsT             nextFlags;

  assign op = (aluSrc == aluSrcInstr) ? opcode : ctrlOp;

  // Adder operands, subtraction as X + ~Y + carry
  always_comb
  begin
    addX    = a;
    addY    = b;
    addCin  = 1'b0;
    isArith = 1'b1;
    case (op)
      opSub, opCmp:
      begin
        addY   = ~b;
        addCin = 1'b1;
      end
      opRsb:
      begin
        addX   = b;
        addY   = ~a;
        addCin = 1'b1;
      end
      opSbc:
      begin
        addY   = ~b;
        addCin = flags.c;
      end
      opRsc:
      begin
        addX   = b;
        addY   = ~a;
        addCin = flags.c;
      end
      opAdc:     addCin = flags.c;
      opAdd, opCmn:
      begin
        addY = b;
      end
      opAPlus4:  addY = wordT'(`PC_STEP);
      opAPlusB4: addY = b + wordT'(`PC_STEP);
      default:   isArith = 1'b0;
    endcase
  end

  assign sum = {1'b0, addX} + {1'b0, addY} + {{`DATA_WIDTH{1'b0}}, addCin};
  assign overflow = (addX[`DATA_WIDTH-1] == addY[`DATA_WIDTH-1]) &&
                    (sum[`DATA_WIDTH-1] != addX[`DATA_WIDTH-1]);

  always_comb
  begin
    case (op)
      opAnd, opTst: result = a & b;
      opEor, opTeq: result = a ^ b;
      opOrr:        result = a | b;
      opMov:        result = b;
      opBic:        result = a & ~b;
      opMvn:        result = ~b;
      opPassA:      result = a;
      default:      result = sum[`DATA_WIDTH-1:0];
    endcase
  end

  assign isTest = op inside {opTst, opTeq, opCmp, opCmn};

  // Logic ops keep C and clear V
  assign nextFlags.n = result[`DATA_WIDTH-1];
  assign nextFlags.z = (result == '0);
  assign nextFlags.c = isArith ? sum[`DATA_WIDTH] : flags.c;
  assign nextFlags.v = isArith ? overflow : 1'b0;

  always_ff @(posedge clk)
  begin
    if (!rstN)
      flags <= '0;
    else if (flagsEn && (sBit || isTest))
      flags <= nextFlags;
  end

endmodule

// File: logic/controlRom.sv
// Microcode control ROM
`include "datapath_config.svh"

module controlRom (
  input  datapathPkg::stateT    state,
  output datapathPkg::ctrlWordT ctrl,
  output logic                  ready
);
  import datapathPkg::*;

  always_comb
  begin
    // Unlisted states do nothing and fall back to reset
    ctrl         = '0;
    ctrl.aSel    = aSelPc;
    ctrl.cSel    = cSelPc;
    ctrl.bSel    = bSelImm;
    ctrl.aluSrc  = aluSrcFixed;
    ctrl.aluOp   = opPassA;
    ctrl.nextSel = 3'd1;
    ctrl.target  = stFetch;
    case (state)
      stReset:
      begin
        ctrl.nextSel = 3'd2;
      end
      stFetch:
      begin
        // Hold here until the host strobe, then step to decode
        ctrl.aluOp   = opAPlus4;
        ctrl.rfEn    = 1'b1;
        ctrl.irEn    = 1'b1;
        ctrl.nextSel = 3'd5;
        ctrl.condSel = 2'd2;
        ctrl.inv     = 1'b1;
      end
      stDecode:
      begin
        ctrl.nextSel = 3'd0;
      end
      stDataImm:
      begin
        ctrl.aSel    = aSelRn;
        ctrl.cSel    = cSelRd;
        ctrl.aluSrc  = aluSrcInstr;
        ctrl.rfEn    = 1'b1;
        ctrl.flagsEn = 1'b1;
        ctrl.nextSel = 3'd2;
      end
      stBranch:
      begin
        ctrl.bSel    = bSelOffset;
        ctrl.aluOp   = opAPlusB4;
        ctrl.rfEn    = 1'b1;
        ctrl.nextSel = 3'd2;
      end
      stLink:
      begin
        ctrl.cSel    = cSelLr;
        ctrl.rfEn    = 1'b1;
        ctrl.nextSel = 3'd2;
        ctrl.target  = stBranch;
      end
      default:
      begin
        ctrl.nextSel = 3'd1;
      end
    endcase
  end

  assign ready = (state == stFetch);

endmodule

// File: logic/microSequencer.sv
// Microsequencer
`include "datapath_config.svh"

module microSequencer (
  input  logic                 clk,
  input  logic                 rstN,
  input  datapathPkg::wordT    instr,
  input  logic                 instrValid,
  input  datapathPkg::ctrlWordT ctrl,
  output datapathPkg::stateT   state,
  output datapathPkg::regIdxT  rn,
  output datapathPkg::regIdxT  rd,
  output logic [7:0]           imm8,
  output logic [23:0]          offset24,
  output datapathPkg::aluOpT   opcode,
  output logic                 sBit
);
  import datapathPkg::*;

  wordT  ir;
  stateT classState;
  stateT incState;
  stateT nextState;
  logic  condRaw;
  logic  sts;

  // IR only loads on an accepted fetch
  always_ff @(posedge clk)
  begin
    if (!rstN)
      ir <= '0;
    else if (ctrl.irEn && instrValid)
      ir <= instr;
  end

  // Instruction class encoder
  always_comb
  begin
    if (ir[27:25] == 3'b001)
      classState = stDataImm;
    else if (ir[27:25] == 3'b101)
      classState = ir[24] ? stLink : stBranch;
    else
      classState = stFetch;
  end

  always_comb
  begin
    case (ctrl.condSel)
      2'd1:    condRaw = 1'b1;
      2'd2:    condRaw = instrValid;
      default: condRaw = 1'b0;
    endcase
  end

  assign sts = condRaw ^ ctrl.inv;
  assign incState = stateT'(state + 1'b1);

  // Next address select, condition picks between two sources
  always_comb
  begin
    case (ctrl.nextSel)
      3'd0:    nextState = classState;
      3'd1:    nextState = stReset;
      3'd2:    nextState = ctrl.target;
      3'd3:    nextState = incState;
      3'd4:    nextState = sts ? ctrl.target : classState;
      3'd5:    nextState = sts ? ctrl.target : incState;
      3'd6:    nextState = sts ? classState : incState;
      default: nextState = classState;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      state <= stReset;
    else
      state <= nextState;
  end

  // IR fields
  assign rn       = ir[19:16];
  assign rd       = ir[15:12];
  assign imm8     = ir[7:0];
  assign offset24 = ir[23:0];
  assign opcode   = aluOpT'({1'b0, ir[24:21]});
  assign sBit     = ir[20];

endmodule

// File: logic/datapath_pkg.sv
// Datapath types
`include "datapath_config.svh"

package datapathPkg;

  typedef logic [`DATA_WIDTH-1:0] wordT;
  typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

  typedef enum logic [`STATE_WIDTH-1:0] {
    stReset   = 8'd0,
    stFetch   = 8'd1,
    stDecode  = 8'd2,
    stDataImm = 8'd5,
    stBranch  = 8'd10,
    stLink    = 8'd11
  } stateT;

  // Codes 0-15 follow the instruction opcode field
  typedef enum logic [4:0] {
    opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn,
    opPassA   = 5'd16,
    opAPlus4  = 5'd17,
    opAPlusB4 = 5'd18
  } aluOpT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef enum logic {aSelRn, aSelPc} aSelT;
  typedef enum logic [1:0] {cSelRd, cSelPc, cSelLr} cSelT;
  typedef enum logic {bSelImm, bSelOffset} bSelT;
  typedef enum logic {aluSrcInstr, aluSrcFixed} aluSrcT;

  typedef struct packed {
    aSelT       aSel;
    cSelT       cSel;
    bSelT       bSel;
    aluSrcT     aluSrc;
    aluOpT      aluOp;
    logic       rfEn;
    logic       irEn;
    logic       flagsEn;
    logic [2:0] nextSel;
    logic [1:0] condSel;
    logic       inv;
    stateT      target;
  } ctrlWordT;

endpackage

// File: logic/datapath_config.svh
// Datapath configuration
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// Word and register file sizes
`define DATA_WIDTH 32
`define REG_COUNT 16

// Micro-state width
`define STATE_WIDTH 8

// Dedicated register indices
`define PC_INDEX 15
`define LINK_INDEX 14

// PC increment per fetch and branch offset scaling
`define PC_STEP 4
`define OFFSET_SHIFT 2

`endif
